//--- cpu.f
rtl/cpu_pkg.sv
rtl/cpu_alu.sv
rtl/cpu_bus_wb8.sv
rtl/cpu_regfile.sv
rtl/cpu_control.sv
rtl/cpu.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cpu regression with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cpu_tb \
    -f cpu.f \
    -o cpu_sim

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/cpu_sim

//--- verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    logic        clk;
    logic        reset;
    logic [31:0] wb_adr;
    logic [7:0]  wb_dat_wr;
    logic [7:0]  wb_dat_rd;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_ack;

    logic [7:0]  mem [4096];     // bus side memory
    logic [7:0]  m_mem [4096];   // model memory
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic [31:0] rng_state = 32'h9938;
    logic [31:0] final_addr;
    logic [31:0] exp_adr [$];
    logic        exp_we [$];
    logic [7:0]  exp_dat [$];
    int          final_hits = 0;
    int          wait_left = 0;
    int          cycles = 0;
    int          cycle_limit = 100000;
    int          gen_pc;

    cpu #(.reset_vector(32'h0)) cpu_inst (.*);

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic void put(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            mem[gen_pc + i]   = w[8*i +: 8];
            m_mem[gen_pc + i] = w[8*i +: 8];
        end
        gen_pc += 4;
    endfunction

    // random op or op_imm instruction on x0..x15
    function automatic logic [31:0] rand_alu();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        r   = xorshift();
        f3  = r[14:12];
        imm = r[31:20];
        if (r[15])
            return {((f3 == 3'd0 || f3 == 3'd5) && r[16]) ? 7'h20 : 7'h00,
                    1'b0, r[11:8], 1'b0, r[7:4], f3, 1'b0, r[3:0], {op, 2'b11}};
        if (f3 == 3'd1)
            imm = {7'h00, r[24:20]};
        if (f3 == 3'd5)
            imm = {r[16] ? 7'h20 : 7'h00, r[24:20]};   // srai or srli
        return {imm, 1'b0, r[7:4], f3, 1'b0, r[3:0], {op_imm, 2'b11}};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void push_word(input logic [31:0] addr, input logic we,
                                      input logic [31:0] data);
        for (int i = 0; i < 4; i++) begin
            exp_adr.push_back(addr + 32'(i));
            exp_we.push_back(we);
            exp_dat.push_back(data[8*i +: 8]);
        end
    endfunction

    // one instruction on the model: expected bus beats, registers and next pc
    function automatic void ref_step();
        instr_t      in;
        logic [31:0] w, a, b, res, nxt, ea, imm_i;
        logic        wr;
        logic        tk;
        w     = {m_mem[m_pc[11:0] + 3], m_mem[m_pc[11:0] + 2],
                 m_mem[m_pc[11:0] + 1], m_mem[m_pc[11:0]]};
        in    = w;
        a     = m_regs[in.r.rs1];
        b     = m_regs[in.r.rs2];
        imm_i = {{20{in.i.imm[11]}}, in.i.imm};
        nxt   = m_pc + 32'd4;
        res   = '0;
        wr    = 1'b0;
        push_word(m_pc, 1'b0, '0);
        case (opcode_t'(w[6:2]))
            op: begin
                res = alu_ref(in.r.funct3, in.r.funct7[5], a, b);
                wr  = 1'b1;
            end
            op_imm: begin
                res = alu_ref(in.r.funct3, in.r.funct3 == 3'd5 && in.r.funct7[5], a, imm_i);
                wr  = 1'b1;
            end
            lui: begin
                res = {w[31:12], 12'b0};
                wr  = 1'b1;
            end
            auipc: begin
                res = m_pc + {w[31:12], 12'b0};
                wr  = 1'b1;
            end
            jal: begin
                res = m_pc + 32'd4;
                wr  = 1'b1;
                nxt = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            jalr: begin
                res = m_pc + 32'd4;
                wr  = 1'b1;
                nxt = (a + imm_i) & ~32'd1;
            end
            branch: begin
                case (in.r.funct3)
                    3'd0:    tk = a == b;
                    3'd1:    tk = a != b;
                    3'd4:    tk = $signed(a) < $signed(b);
                    3'd5:    tk = $signed(a) >= $signed(b);
                    3'd6:    tk = a < b;
                    default: tk = a >= b;
                endcase
                if (tk)
                    nxt = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            load: begin
                ea  = a + imm_i;
                res = {m_mem[ea[11:0] + 3], m_mem[ea[11:0] + 2],
                       m_mem[ea[11:0] + 1], m_mem[ea[11:0]]};
                wr  = 1'b1;
                push_word(ea, 1'b0, '0);
            end
            store: begin
                ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
                for (int i = 0; i < 4; i++)
                    m_mem[ea[11:0] + i] = b[8*i +: 8];
                push_word(ea, 1'b1, b);
            end
            default: ;   // everything else is a no-op
        endcase
        if (wr && in.r.rd != 5'd0)
            m_regs[in.r.rd] = res;
        m_pc = nxt;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        logic [31:0] r;
        reset     = 1'b1;
        wb_ack    = 1'b0;
        wb_dat_rd = 8'h00;
        for (int i = 0; i < 4096; i++) begin
            mem[i]   = 8'(i) ^ {4'h0, 4'(i >> 8)} ^ 8'h5a;
            m_mem[i] = mem[i];
        end
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        m_pc   = '0;
        gen_pc = 0;
        for (int i = 1; i < 16; i++) begin   // seed x1..x15 with lui
            r = xorshift();
            put({r[31:12], 5'(i), {lui, 2'b11}});
        end
        // each branch condition with equal operands, then 0 against x31
        put({20'h00001, 5'd31, {lui, 2'b11}});   // x31 = 4096, positive
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                put({7'h00, 5'd31, 5'd31, 3'(f), 5'b01000, {branch, 2'b11}});
                put(rand_alu());
                put({7'h00, 5'd31, 5'd0, 3'(f), 5'b01000, {branch, 2'b11}});
                put(rand_alu());
            end
        end
        while (gen_pc < 4 * 76) begin
            r = xorshift();
            case (r % 10)
                0, 1, 2: put(rand_alu());
                3: put({r[31:12], 1'b0, r[3:0], {lui, 2'b11}});
                4: put({r[31:12], 1'b0, r[3:0], {auipc, 2'b11}});
                5: put({6'h10, r[11], 1'b0, r[7:4], 5'd0, 3'b010, r[10:8], 2'b00,
                        {store, 2'b11}});
                6: begin   // load a stored slot, then store the loaded register
                    put({6'h10, r[7:4], 2'b00, 5'd0, 3'b010, 1'b0, r[3:0], {load, 2'b11}});
                    put({6'h10, r[11], 1'b0, r[3:0], 5'd0, 3'b010, r[10:8], 2'b00,
                         {store, 2'b11}});
                end
                7: begin   // forward branch over a filler
                    put({7'h00, 1'b0, r[7:4], 1'b0, r[11:8],
                         (r[13] && !r[14]) ? {r[12], 2'b01} : r[14:12],
                         5'b01000, {branch, 2'b11}});
                    put(rand_alu());
                end
                8: begin
                    put({20'h00800, 1'b0, r[3:0], {jal, 2'b11}});   // jal +8
                    put(rand_alu());
                end
                default: begin
                    put({20'h0, 5'd31, {auipc, 2'b11}});
                    put({12'd12, 5'd31, 3'b000, 1'b0, r[3:0], {jalr, 2'b11}});
                    put(rand_alu());
                end
            endcase
        end
        final_addr = 32'(gen_pc);
        put({20'h0, 5'd0, {jal, 2'b11}});   // jal to self
        cycle_limit = (gen_pc / 4 + 4) * 48 + 10;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    end

    // memory model with 0 to 2 wait cycles per beat
    always @(posedge clk) begin
        if (reset) begin
            wait_left = int'(xorshift() % 3);
        end else if (wb_stb && wb_ack) begin
            if (wb_we)
                mem[wb_adr[11:0]] = wb_dat_wr;
            wait_left = int'(xorshift() % 3);
            #1 wb_ack = 1'b0;
        end else if (wb_stb) begin
            if (wait_left == 0) begin
                #1;
                wb_dat_rd = mem[wb_adr[11:0]];
                wb_ack    = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    // every acked beat against the model
    always @(posedge clk) begin
        logic [31:0] ea;
        logic        ew;
        logic [7:0]  ed;
        if (!reset && wb_stb && wb_ack) begin
            if (exp_adr.size() == 0 && m_pc == final_addr)
                final_hits++;
            if (final_hits == 2) begin
                $display("Regression passed");
                $finish;
            end else begin
                if (exp_adr.size() == 0)
                    ref_step();
                ea = exp_adr.pop_front();
                ew = exp_we.pop_front();
                ed = exp_dat.pop_front();
                check_value("wb_adr", ea, wb_adr);
                check_value("wb_we", {31'b0, ew}, {31'b0, wb_we});
                if (ew)
                    check_value("wb_dat_wr", {24'b0, ed}, {24'b0, wb_dat_wr});
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the core stopped reaching the final loop");
            $display("Regression failed");
            $fatal(1, "timeout after %0d cycles", cycles);
        end
    end

endmodule

//--- verif/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker import cpu_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic [xlen-1:0] wb_adr,
    input logic [7:0]      wb_dat_wr,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic            wb_we,
    input logic            wb_ack
);

    stb_in_cycle: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // request held until the memory acknowledges
    beat_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_we)
                                 && $stable(wb_dat_wr)))
        else $error("bus request changed before wb_ack");

    idle_after_reset: assert property (@(posedge clk) reset |=> !wb_cyc)
        else $error("wb_cyc high right after reset");

endmodule

bind cpu cpu_checker checker_inst (.*);

//--- rtl/cpu.sv
`timescale 1ns/1ps

module cpu import cpu_pkg::*; #(
    parameter logic [xlen-1:0] reset_vector = '0
) (
    input  logic            clk,
    input  logic            reset,
    output logic [xlen-1:0] wb_adr,
    output logic [7:0]      wb_dat_wr,
    input  logic [7:0]      wb_dat_rd,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    input  logic            wb_ack
);

    logic                  bus_start;
    logic                  bus_write;
    logic [xlen-1:0]       bus_addr;
    logic                  bus_busy;
    logic                  bus_done;
    logic [xlen-1:0]       bus_rdata;

    logic                  alu_en;
    alu_op_t               alu_op;
    logic [xlen-1:0]       alu_a;
    logic [xlen-1:0]       alu_b;
    logic [xlen-1:0]       alu_result;
    logic                  alu_eq;
    logic                  alu_lt;
    logic                  alu_ltu;

    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_we;
    logic [xlen-1:0]       rd_data;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;

    cpu_control #(
        .reset_vector(reset_vector)
    ) control_inst (
        .clk, .reset,
        .bus_busy, .bus_done, .bus_rdata,
        .alu_result, .alu_eq, .alu_lt, .alu_ltu,
        .rs1_val, .rs2_val,
        .bus_start, .bus_write, .bus_addr,
        .alu_en, .alu_op, .alu_a, .alu_b,
        .rs1, .rs2, .rd, .rd_we, .rd_data
    );

    cpu_alu alu_inst (
        .clk, .reset,
        .alu_en, .alu_op, .alu_a, .alu_b,
        .alu_result, .alu_eq, .alu_lt, .alu_ltu
    );

    cpu_bus_wb8 bus_inst (
        .clk, .reset,
        .bus_start, .bus_write, .bus_addr,
        .bus_wdata (rs2_val),   // store word
        .wb_ack, .wb_dat_rd,
        .bus_busy, .bus_done, .bus_rdata,
        .wb_adr, .wb_dat_wr, .wb_cyc, .wb_stb, .wb_we
    );

    cpu_regfile regfile_inst (
        .clk,
        .rs1, .rs2, .rd, .rd_we, .rd_data,
        .rs1_val, .rs2_val
    );

endmodule

//--- rtl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; #(
    parameter logic [xlen-1:0] reset_vector = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bus_busy,
    input  logic                  bus_done,
    input  logic [xlen-1:0]       bus_rdata,
    input  logic [xlen-1:0]       alu_result,
    input  logic                  alu_eq,
    input  logic                  alu_lt,
    input  logic                  alu_ltu,
    input  logic [xlen-1:0]       rs1_val,
    input  logic [xlen-1:0]       rs2_val,
    output logic                  bus_start,
    output logic                  bus_write,
    output logic [xlen-1:0]       bus_addr,
    output logic                  alu_en,
    output alu_op_t               alu_op,
    output logic [xlen-1:0]       alu_a,
    output logic [xlen-1:0]       alu_b,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd,
    output logic                  rd_we,
    output logic [xlen-1:0]       rd_data
);

    localparam logic [3:0] fetch         = 4'd0;
    localparam logic [3:0] fetch_wait    = 4'd1;
    localparam logic [3:0] decode        = 4'd2;
    localparam logic [3:0] exec          = 4'd3;
    localparam logic [3:0] mem           = 4'd4;
    localparam logic [3:0] mem_wait      = 4'd5;
    localparam logic [3:0] writeback     = 4'd6;
    localparam logic [3:0] branch_decide = 4'd7;
    localparam logic [3:0] pc_load       = 4'd8;

    // write-back sources
    localparam logic [1:0] wb_alu  = 2'd0;
    localparam logic [1:0] wb_bus  = 2'd1;
    localparam logic [1:0] wb_imm  = 2'd2;
    localparam logic [1:0] wb_link = 2'd3;

    logic [3:0]      state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    instr_t          instr;
    opcode_t         opcode;
    logic [xlen-1:0] imm;
    alu_op_t         alu_fn;
    logic            taken;
    logic [1:0]      wb_sel;

    assign opcode = opcode_t'(instr.r.opcode[6:2]);
    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;

    // immediate by format, s/b/u/j rebuilt from the r fields
    always_comb begin
        case (opcode)
            store:       imm = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
            branch:      imm = {{20{instr.r.funct7[6]}}, instr.r.rd[0], instr.r.funct7[5:0],
                                instr.r.rd[4:1], 1'b0};
            lui, auipc:  imm = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3,
                                12'b0};
            jal:         imm = {{12{instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3,
                                instr.r.rs2[0], instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};
            default:     imm = {{20{instr.i.imm[11]}}, instr.i.imm};
        endcase
    end

    always_comb begin
        alu_fn = alu_add;
        if (opcode == op || opcode == op_imm) begin
            case (instr.r.funct3)
                f3_add_sub: alu_fn = (opcode == op && instr.r.funct7[5]) ? alu_sub : alu_add;
                f3_sll:     alu_fn = alu_sll;
                f3_slt:     alu_fn = alu_slt;
                f3_sltu:    alu_fn = alu_sltu;
                f3_xor:     alu_fn = alu_xor;
                f3_srl_sra: alu_fn = instr.r.funct7[5] ? alu_sra : alu_srl;
                f3_or:      alu_fn = alu_or;
                f3_and:     alu_fn = alu_and;
                default:    alu_fn = alu_add;
            endcase
        end
    end

    always_comb begin
        case (instr.r.funct3)
            beq:     taken = alu_eq;
            bne:     taken = !alu_eq;
            blt:     taken = alu_lt;
            bge:     taken = !alu_lt;
            bltu:    taken = alu_ltu;
            bgeu:    taken = !alu_ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        alu_en = 1'b0;
        alu_op = alu_add;
        alu_a  = rs1_val;
        alu_b  = imm;
        if (state == exec) begin
            alu_en = 1'b1;
            alu_op = alu_fn;   // plain add for addresses and branch compares
            if (opcode == auipc || opcode == jal)
                alu_a = pc;
            if (opcode == op || opcode == branch)
                alu_b = rs2_val;
        end else if (state == branch_decide) begin
            alu_en = taken;   // target pc + imm, flags from exec still valid
            alu_a  = pc;
        end
    end

    always_comb begin
        rd_we  = 1'b0;
        wb_sel = wb_alu;
        case (state)
            exec: begin
                if (opcode == lui) begin
                    rd_we  = 1'b1;
                    wb_sel = wb_imm;
                end else if (opcode == jal || opcode == jalr) begin
                    rd_we  = 1'b1;
                    wb_sel = wb_link;
                end
            end
            writeback: rd_we = 1'b1;
            mem_wait: begin
                rd_we  = bus_done && (opcode == load);
                wb_sel = wb_bus;
            end
            default: rd_we = 1'b0;
        endcase
        case (wb_sel)
            wb_alu:  rd_data = alu_result;
            wb_bus:  rd_data = bus_rdata;
            wb_imm:  rd_data = imm;
            default: rd_data = pc_plus4;
        endcase
    end

    // address and direction are sampled by the bus master with bus_start
    assign bus_addr  = (state == mem_wait) ? alu_result : pc;
    assign bus_write = (state == mem_wait) && (opcode == store);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= fetch;
            pc        <= reset_vector;
            bus_start <= 1'b0;
        end else begin
            bus_start <= 1'b0;
            case (state)
                fetch: begin
                    if (!bus_busy) begin
                        bus_start <= 1'b1;
                        state     <= fetch_wait;
                    end
                end
                fetch_wait: if (bus_done) state <= decode;
                decode:     state <= exec;
                exec: begin
                    case (opcode)
                        op, op_imm, auipc: state <= writeback;
                        load, store:       state <= mem;
                        branch:            state <= branch_decide;
                        jal, jalr:         state <= pc_load;
                        default: begin   // lui, fence, system and unknown
                            pc    <= pc_plus4;
                            state <= fetch;
                        end
                    endcase
                end
                mem: begin
                    if (!bus_busy) begin
                        bus_start <= 1'b1;
                        state     <= mem_wait;
                    end
                end
                branch_decide: begin
                    if (taken) begin
                        state <= pc_load;
                    end else begin
                        pc    <= pc_plus4;
                        state <= fetch;
                    end
                end
                pc_load: begin
                    pc    <= (opcode == jalr) ? {alu_result[xlen-1:1], 1'b0} : alu_result;
                    state <= fetch;
                end
                writeback: begin
                    pc    <= pc_plus4;
                    state <= fetch;
                end
                mem_wait: begin
                    if (bus_done) begin
                        pc    <= pc_plus4;
                        state <= fetch;
                    end
                end
                default: state <= fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_wait && bus_done)
            instr <= bus_rdata;
        if (state == decode)
            pc_plus4 <= pc + 32'd4;
    end

endmodule

//--- rtl/cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile import cpu_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] rd,
    input  logic                  rd_we,
    input  logic [xlen-1:0]       rd_data,
    output logic [xlen-1:0]       rs1_val,
    output logic [xlen-1:0]       rs2_val
);

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (rd_we && rd != '0)
            regs[rd] <= rd_data;
    end

    // x0 is never written, so force it here
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- rtl/cpu_bus_wb8.sv
`timescale 1ns/1ps

module cpu_bus_wb8 import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            bus_start,
    input  logic            bus_write,
    input  logic [xlen-1:0] bus_addr,
    input  logic [xlen-1:0] bus_wdata,
    input  logic            wb_ack,
    input  logic [7:0]      wb_dat_rd,
    output logic            bus_busy,
    output logic            bus_done,
    output logic [xlen-1:0] bus_rdata,
    output logic [xlen-1:0] wb_adr,
    output logic [7:0]      wb_dat_wr,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we
);

    localparam int beat_w = $clog2(bus_beats);

    localparam logic [1:0] s_idle   = 2'd0;
    localparam logic [1:0] s_strobe = 2'd1;   // cyc/stb up, waiting for ack
    localparam logic [1:0] s_gap    = 2'd2;   // one low cycle between beats
    localparam logic [1:0] s_done   = 2'd3;

    logic [1:0]        state;
    logic [beat_w-1:0] beat;
    logic [xlen-1:0]   base_addr;
    logic [xlen-1:0]   wdata;
    logic              write;
    logic              last_beat;

    assign last_beat = (beat == beat_w'(bus_beats - 1));

    assign wb_cyc    = (state == s_strobe);
    assign wb_stb    = (state == s_strobe);
    assign wb_we     = write & (state == s_strobe);
    assign wb_adr    = base_addr + xlen'(beat);
    assign wb_dat_wr = wdata[{beat, 3'b000} +: 8];   // lsb first

    assign bus_busy  = (state == s_strobe) || (state == s_gap);
    assign bus_done  = (state == s_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
            beat  <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (bus_start) begin
                        state <= s_strobe;
                        beat  <= '0;
                    end
                end
                s_strobe: begin
                    if (wb_ack) begin
                        state <= last_beat ? s_done : s_gap;
                        beat  <= beat + 1'b1;
                    end
                end
                s_gap:   state <= s_strobe;
                default: state <= s_idle;
            endcase
        end
    end

    // request latch and read assembly
    always_ff @(posedge clk) begin
        if (state == s_idle && bus_start) begin
            base_addr <= bus_addr;
            wdata     <= bus_wdata;
            write     <= bus_write;
        end
        if (state == s_strobe && wb_ack && !write)
            bus_rdata <= {wb_dat_rd, bus_rdata[xlen-1:8]};   // bytes enter at the top
    end

endmodule

//--- rtl/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            alu_en,
    input  alu_op_t         alu_op,
    input  logic [xlen-1:0] alu_a,
    input  logic [xlen-1:0] alu_b,
    output logic [xlen-1:0] alu_result,
    output logic            alu_eq,
    output logic            alu_lt,
    output logic            alu_ltu
);

    logic [xlen-1:0] result_next;
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;

    assign shamt = alu_b[4:0];   // only the low 5 bits count for shifts
    assign lt_s  = $signed(alu_a) < $signed(alu_b);
    assign lt_u  = alu_a < alu_b;

    always_comb begin
        case (alu_op)
            alu_add:  result_next = alu_a + alu_b;
            alu_sub:  result_next = alu_a - alu_b;
            alu_sll:  result_next = alu_a << shamt;
            alu_slt:  result_next = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu: result_next = {{(xlen-1){1'b0}}, lt_u};
            alu_xor:  result_next = alu_a ^ alu_b;
            alu_srl:  result_next = alu_a >> shamt;
            alu_sra:  result_next = $signed(alu_a) >>> shamt;   // keeps the sign
            alu_or:   result_next = alu_a | alu_b;
            default:  result_next = alu_a & alu_b;
        endcase
    end

    // result and flags hold until the next enable
    always_ff @(posedge clk) begin
        if (reset) begin
            alu_result <= '0;
            alu_eq     <= 1'b0;
            alu_lt     <= 1'b0;
            alu_ltu    <= 1'b0;
        end else if (alu_en) begin
            alu_result <= result_next;
            alu_eq     <= (alu_a == alu_b);
            alu_lt     <= lt_s;
            alu_ltu    <= lt_u;
        end
    end

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int bus_beats  = 4;   // bytes per word on the 8-bit bus

    // instruction bits [6:2], the low two bits are always 2'b11
    typedef enum logic [4:0] {
        load   = 5'b00000,
        op_imm = 5'b00100,
        auipc  = 5'b00101,
        store  = 5'b01000,
        op     = 5'b01100,
        lui    = 5'b01101,
        branch = 5'b11000,
        jalr   = 5'b11001,
        jal    = 5'b11011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // branch conditions
    localparam logic [2:0] beq  = 3'b000;
    localparam logic [2:0] bne  = 3'b001;
    localparam logic [2:0] blt  = 3'b100;
    localparam logic [2:0] bge  = 3'b101;
    localparam logic [2:0] bltu = 3'b110;
    localparam logic [2:0] bgeu = 3'b111;

    // alu groups, shared by op and op_imm
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0]           imm;   // sign bit is instruction bit 31
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

endpackage
